// ==== verilog/vcluster_pkg.sv ====
package vcluster_pkg;

  //////////////////////////////
  // Cluster geometry
  //////////////////////////////

  // Number of vector clusters fed by the broadcast stage
  localparam int unsigned NrClusters = 4;

  // Bits per cluster element
  localparam int unsigned ElemWidth = 16;

  // Gathered result word, one element slice per cluster
  localparam int unsigned ResWidth = NrClusters * ElemWidth;

  //////////////////////////////
  // Data types
  //////////////////////////////

  // Operand and element value
  typedef logic [ElemWidth-1:0] elem_t;

  // Concatenated result, cluster 0 in the low bits
  typedef logic [ResWidth-1:0] res_t;

  // One bit per cluster
  typedef logic [NrClusters-1:0] cluster_mask_t;

  //////////////////////////////
  // Operations
  //////////////////////////////

  // Set loads operand plus cluster index; add and xor work on the element
  typedef enum logic [1:0] {
    OP_SET = 2'd0,
    OP_ADD = 2'd1,
    OP_XOR = 2'd2
  } cmd_op_e;

endpackage

// ==== verilog/cmd_if.sv ====
`timescale 1ns/10ps

// One command link from the broadcaster to a single cluster
interface cmd_if;

  logic                  valid;
  logic                  ready;
  vcluster_pkg::cmd_op_e op;
  vcluster_pkg::elem_t   operand;

  // Broadcaster side
  modport bcast (
    output valid,
    output op,
    output operand,
    input  ready
  );

  // Cluster side
  modport cluster (
    input  valid,
    input  op,
    input  operand,
    output ready
  );

endinterface

// ==== verilog/cmd_broadcast.sv ====
`timescale 1ns/10ps

module cmd_broadcast (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  cmd_valid_i,
  output logic                  cmd_ready_o,
  input  vcluster_pkg::cmd_op_e cmd_op_i,
  input  vcluster_pkg::elem_t   cmd_operand_i,
  cmd_if.bcast                  clus [vcluster_pkg::NrClusters]
);

  // Held command
  logic                        full_q;
  vcluster_pkg::cmd_op_e       op_q;
  vcluster_pkg::elem_t         operand_q;
  // Clusters that already have the held command
  vcluster_pkg::cluster_mask_t taken_q;

  vcluster_pkg::cluster_mask_t clus_valid;
  vcluster_pkg::cluster_mask_t clus_ready;
  vcluster_pkg::cluster_mask_t take;
  logic                        all_taken;
  logic                        drain;
  logic                        accept;

  //////////////////////////////
  // Per-cluster links
  //////////////////////////////

  assign clus_valid = full_q ? ~taken_q : '0;
  assign take       = clus_valid & clus_ready;

  for (genvar k = 0; k < vcluster_pkg::NrClusters; k++) begin : g_link
    assign clus[k].valid   = clus_valid[k];
    assign clus[k].op      = op_q;
    assign clus[k].operand = operand_q;
    assign clus_ready[k]   = clus[k].ready;
  end

  //////////////////////////////
  // Command register
  //////////////////////////////

  // Counts takes landing on this edge
  assign all_taken   = &(taken_q | take);
  assign drain       = full_q & all_taken;
  assign cmd_ready_o = ~full_q | all_taken;
  assign accept      = cmd_valid_i & cmd_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q  <= 1'b0;
      taken_q <= '0;
    end else begin
      if (accept) begin
        full_q  <= 1'b1;
        taken_q <= '0;
      end else if (drain) begin
        full_q  <= 1'b0;
        taken_q <= '0;
      end else begin
        taken_q <= taken_q | take;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q      <= cmd_op_i;
      operand_q <= cmd_operand_i;
    end
  end

endmodule

// ==== verilog/vector_cluster.sv ====
`timescale 1ns/10ps

module vector_cluster #(
  parameter int unsigned ClusterId = 0
) (
  input  logic                clk_i,
  input  logic                reset_i,
  cmd_if.cluster              cmd,
  output logic                res_valid_o,
  input  logic                res_ready_i,
  output vcluster_pkg::elem_t res_elem_o
);

  vcluster_pkg::elem_t elem_q;
  vcluster_pkg::elem_t elem_d;
  logic                out_valid_q;
  vcluster_pkg::elem_t out_elem_q;
  logic                take;

  // Free slot or slot draining on this edge
  assign cmd.ready = ~out_valid_q | res_ready_i;
  assign take      = cmd.valid & cmd.ready;

  //////////////////////////////
  // Operation unit
  //////////////////////////////

  always_comb begin
    case (cmd.op)
      vcluster_pkg::OP_SET: elem_d = cmd.operand + vcluster_pkg::elem_t'(ClusterId);
      vcluster_pkg::OP_ADD: elem_d = elem_q + cmd.operand;
      vcluster_pkg::OP_XOR: elem_d = elem_q ^ cmd.operand;
      // Unused encoding keeps the element
      default:              elem_d = elem_q;
    endcase
  end

  //////////////////////////////
  // Element and output regs
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      elem_q      <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (take) begin
        elem_q      <= elem_d;
        out_valid_q <= 1'b1;
      end else if (res_ready_i) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      out_elem_q <= elem_d;
    end
  end

  assign res_valid_o = out_valid_q;
  assign res_elem_o  = out_elem_q;

endmodule

// ==== verilog/result_gather.sv ====
`timescale 1ns/10ps

module result_gather (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  vcluster_pkg::cluster_mask_t elem_valid_i,
  output vcluster_pkg::cluster_mask_t elem_ready_o,
  input  vcluster_pkg::elem_t         elem_i [vcluster_pkg::NrClusters],
  output logic                        res_valid_o,
  input  logic                        res_ready_i,
  output vcluster_pkg::res_t          res_data_o
);

  logic               valid_q;
  vcluster_pkg::res_t data_q;
  vcluster_pkg::res_t data_d;
  logic               all_valid;
  logic               can_load;
  logic               load;

  //////////////////////////////
  // Join of cluster results
  //////////////////////////////

  assign all_valid = &elem_valid_i;
  assign can_load  = ~valid_q | res_ready_i;
  assign load      = all_valid & can_load;

  // All clusters hand over on the same edge
  assign elem_ready_o = load ? '1 : '0;

  // Cluster k lands at k*ElemWidth
  always_comb begin
    data_d = '0;
    for (int k = 0; k < vcluster_pkg::NrClusters; k++) begin
      data_d[k*vcluster_pkg::ElemWidth +: vcluster_pkg::ElemWidth] = elem_i[k];
    end
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      if (load) begin
        valid_q <= 1'b1;
      end else if (res_ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= data_d;
    end
  end

  assign res_valid_o = valid_q;
  assign res_data_o  = data_q;

endmodule

// ==== verilog/vcluster_top.sv ====
`timescale 1ns/10ps

module vcluster_top (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // Command stream
  input  logic                  cmd_valid_i,
  output logic                  cmd_ready_o,
  input  vcluster_pkg::cmd_op_e cmd_op_i,
  input  vcluster_pkg::elem_t   cmd_operand_i,
  // Result stream
  output logic                  res_valid_o,
  input  logic                  res_ready_i,
  output vcluster_pkg::res_t    res_data_o
);

  // Broadcast links, one per cluster
  cmd_if cmd_link [vcluster_pkg::NrClusters] ();

  // Cluster to gather links
  vcluster_pkg::cluster_mask_t clus_res_valid;
  vcluster_pkg::cluster_mask_t clus_res_ready;
  vcluster_pkg::elem_t         clus_res_elem [vcluster_pkg::NrClusters];

  //////////////////////////////
  // Command broadcast
  //////////////////////////////

  cmd_broadcast u_bcast (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_ready_o   (cmd_ready_o),
    .cmd_op_i      (cmd_op_i),
    .cmd_operand_i (cmd_operand_i),
    .clus          (cmd_link)
  );

  //////////////////////////////
  // Clusters
  //////////////////////////////

  for (genvar k = 0; k < vcluster_pkg::NrClusters; k++) begin : g_cluster
    vector_cluster #(
      .ClusterId (k)
    ) u_cluster (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .cmd         (cmd_link[k]),
      .res_valid_o (clus_res_valid[k]),
      .res_ready_i (clus_res_ready[k]),
      .res_elem_o  (clus_res_elem[k])
    );
  end

  // Gather into one result word
  result_gather u_gather (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .elem_valid_i (clus_res_valid),
    .elem_ready_o (clus_res_ready),
    .elem_i       (clus_res_elem),
    .res_valid_o  (res_valid_o),
    .res_ready_i  (res_ready_i),
    .res_data_o   (res_data_o)
  );

endmodule

// ==== dv/vcluster_assert.sv ====
`timescale 1ns/10ps

module vcluster_assert (
  input logic               clk_i,
  input logic               reset_i,
  input logic               cmd_valid_i,
  input logic               cmd_ready_o,
  input logic               res_valid_o,
  input logic               res_ready_i,
  input vcluster_pkg::res_t res_data_o
);

  int fail_count = 0;

  // Stalled result holds its word
  a_res_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_data_o))
    else begin
      $error("res_data_o changed or res_valid_o dropped while stalled");
      fail_count++;
    end

  a_reset_idle: assert property (@(posedge clk_i)
    $fell(reset_i) |-> !res_valid_o && cmd_ready_o)
    else begin
      $error("DUT not idle in the first cycle after reset");
      fail_count++;
    end

  // Free-flowing pipeline, three stages
  a_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    $past(cmd_valid_i && cmd_ready_o && res_ready_i, 3) && $past(res_ready_i, 2)
      && $past(res_ready_i, 1) |-> res_valid_o)
    else begin
      $error("no result three cycles after an unstalled command");
      fail_count++;
    end

endmodule

bind vcluster_top vcluster_assert u_assert (.*);

// ==== dv/vcluster_checker.sv ====
`timescale 1ns/10ps

module vcluster_checker (
  input logic                  clk_i,
  input logic                  reset_i,
  input logic                  cmd_valid_i,
  input logic                  cmd_ready_i,
  input vcluster_pkg::cmd_op_e cmd_op_i,
  input vcluster_pkg::elem_t   cmd_operand_i,
  input logic                  res_valid_i,
  input logic                  res_ready_i,
  input vcluster_pkg::res_t    res_data_i,
  input logic [8*24-1:0]       test_name_i,
  input logic                  test_done_i,
  input logic                  check_latency_i
);

  vcluster_pkg::res_t model;
  vcluster_pkg::res_t exp_word;
  vcluster_pkg::res_t exp_q [$];
  int                 acc_q [$];
  int                 acc_cycle;
  int                 cycle = 0;
  int                 pending = 0;
  int                 errors = 0;
  int                 tests_run = 0;
  int                 total_results = 0;
  int                 test_results = 0;
  int                 test_errors = 0;
  logic               reset_q = 1'b1;

  // Every element sees the same command; set adds the cluster index
  function automatic vcluster_pkg::res_t apply_cmd(input vcluster_pkg::res_t cur,
                                                   input vcluster_pkg::cmd_op_e op,
                                                   input vcluster_pkg::elem_t operand);
    vcluster_pkg::res_t  nxt;
    vcluster_pkg::elem_t e;
    nxt = cur;
    for (int k = 0; k < vcluster_pkg::NrClusters; k++) begin
      e = cur[k*vcluster_pkg::ElemWidth +: vcluster_pkg::ElemWidth];
      case (op)
        vcluster_pkg::OP_SET: e = operand + vcluster_pkg::elem_t'(k);
        vcluster_pkg::OP_ADD: e = e + operand;
        vcluster_pkg::OP_XOR: e = e ^ operand;
        default:              e = e;
      endcase
      nxt[k*vcluster_pkg::ElemWidth +: vcluster_pkg::ElemWidth] = e;
    end
    return nxt;
  endfunction

  task automatic report_summary(input int assert_fails);
    $display("Summary: %0d tests, %0d results, %0d errors, %0d assertion failures",
             tests_run, total_results, errors, assert_fails);
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      model = '0;
      exp_q.delete();
      acc_q.delete();
    end else begin
      if (reset_q && (!cmd_ready_i || res_valid_i)) begin
        $display("Error in %0s: DUT not idle in the first cycle after reset", test_name_i);
        test_errors++;
      end
      if (cmd_valid_i && cmd_ready_i) begin
        model = apply_cmd(model, cmd_op_i, cmd_operand_i);
        exp_q.push_back(model);
        acc_q.push_back(cycle);
      end
      if (res_valid_i && res_ready_i) begin
        test_results++;
        if (exp_q.size() == 0) begin
          $display("Error in %0s: result %h arrived with no command outstanding",
                   test_name_i, res_data_i);
          test_errors++;
        end else begin
          exp_word  = exp_q.pop_front();
          acc_cycle = acc_q.pop_front();
          if (res_data_i !== exp_word) begin
            $display("[FAIL] %0s expected %h actual %h", test_name_i, exp_word, res_data_i);
            test_errors++;
          end
          if (check_latency_i && (cycle - acc_cycle != 3)) begin
            $display("[FAIL] %0s latency expected 3 actual %0d", test_name_i, cycle - acc_cycle);
            test_errors++;
          end
        end
      end
      if (test_done_i) begin
        $display("%0s: %0d results, %0d errors", test_name_i, test_results, test_errors);
        tests_run++;
        total_results += test_results;
        errors        += test_errors;
        test_results   = 0;
        test_errors    = 0;
      end
    end
    pending = exp_q.size();
    reset_q = reset_i;
    cycle++;
  end

endmodule

// ==== dv/tb_vcluster.sv ====
`timescale 1ns/10ps

module tb_vcluster;

  localparam int ClkPeriod   = 100;
  localparam int ResetCycles = 10;
  // set_all, add_chain, xor_mix, latency, backpressure_random, reset_state
  localparam int NumCmds     = 4 + 8 + 8 + 1 + 200 + 1;
  localparam int LimitCycles = NumCmds * 20 + 2 * ResetCycles;

  logic                  clk_i;
  logic                  reset_i;
  logic                  cmd_valid_i;
  logic                  cmd_ready_o;
  vcluster_pkg::cmd_op_e cmd_op_i;
  vcluster_pkg::elem_t   cmd_operand_i;
  logic                  res_valid_o;
  logic                  res_ready_i;
  vcluster_pkg::res_t    res_data_o;
  logic [8*24-1:0]       test_name;
  logic                  test_done;
  logic                  check_latency;
  logic                  stall_en;
  logic [31:0]           lfsr;

  vcluster_top dut0 (.*);

  vcluster_checker u_checker (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cmd_valid_i     (cmd_valid_i),
    .cmd_ready_i     (cmd_ready_o),
    .cmd_op_i        (cmd_op_i),
    .cmd_operand_i   (cmd_operand_i),
    .res_valid_i     (res_valid_o),
    .res_ready_i     (res_ready_i),
    .res_data_i      (res_data_o),
    .test_name_i     (test_name),
    .test_done_i     (test_done),
    .check_latency_i (check_latency)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(LimitCycles * ClkPeriod);
    $display("Timeout: simulation did not finish within %0d cycles", LimitCycles);
    $display("ERRORS FOUND");
    $finish;
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  // Advance to the falling edge and draw a result stall when enabled
  task automatic next_cycle();
    @(negedge clk_i);
    if (stall_en) res_ready_i = (take_bits(2) != 32'd0);
  endtask

  task automatic send_cmd(input vcluster_pkg::cmd_op_e op, input vcluster_pkg::elem_t operand);
    logic acc;
    cmd_valid_i   = 1'b1;
    cmd_op_i      = op;
    cmd_operand_i = operand;
    acc           = 1'b0;
    while (!acc) begin
      // Ready has settled by mid low phase
      #(ClkPeriod / 4);
      acc = cmd_ready_o;
      @(posedge clk_i);
      next_cycle();
    end
    cmd_valid_i = 1'b0;
  endtask

  task automatic apply_reset();
    reset_i = 1'b1;
    repeat (ResetCycles) next_cycle();
    reset_i = 1'b0;
  endtask

  // Drain outstanding results, then mark the end of the test
  task automatic finish_test();
    while (u_checker.pending != 0) next_cycle();
    test_done = 1'b1;
    next_cycle();
    test_done = 1'b0;
  endtask

  initial begin
    logic [31:0] op_bits;
    lfsr          = 32'h2bbc3025;
    reset_i       = 1'b1;
    cmd_valid_i   = 1'b0;
    cmd_op_i      = vcluster_pkg::OP_SET;
    cmd_operand_i = '0;
    res_ready_i   = 1'b1;
    test_name     = "set_all";
    test_done     = 1'b0;
    check_latency = 1'b0;
    stall_en      = 1'b0;
    apply_reset();

    // Operands near the top wrap in the upper clusters
    send_cmd(vcluster_pkg::OP_SET, 16'h1234);
    send_cmd(vcluster_pkg::OP_SET, 16'hffff);
    send_cmd(vcluster_pkg::OP_SET, 16'hfffd);
    send_cmd(vcluster_pkg::OP_SET, 16'h0000);
    finish_test();

    test_name = "add_chain";
    send_cmd(vcluster_pkg::OP_SET, vcluster_pkg::elem_t'(take_bits(16)));
    repeat (7) send_cmd(vcluster_pkg::OP_ADD, vcluster_pkg::elem_t'(take_bits(16)));
    finish_test();

    test_name = "xor_mix";
    for (int i = 0; i < 8; i++) begin
      op_bits = (i % 2 == 0) ? 32'd2 : 32'd1;
      send_cmd(vcluster_pkg::cmd_op_e'(op_bits[1:0]), vcluster_pkg::elem_t'(take_bits(16)));
    end
    finish_test();

    test_name     = "latency";
    check_latency = 1'b1;
    send_cmd(vcluster_pkg::OP_SET, 16'h00a5);
    finish_test();
    check_latency = 1'b0;

    test_name = "backpressure_random";
    stall_en  = 1'b1;
    repeat (200) begin
      op_bits = take_bits(2);
      op_bits = (op_bits == 32'd3) ? 32'd1 : op_bits;
      send_cmd(vcluster_pkg::cmd_op_e'(op_bits[1:0]), vcluster_pkg::elem_t'(take_bits(16)));
      repeat (take_bits(2)) next_cycle();
    end
    stall_en    = 1'b0;
    res_ready_i = 1'b1;
    finish_test();

    // Elements start at zero, so an add yields the operand everywhere
    test_name = "reset_state";
    apply_reset();
    send_cmd(vcluster_pkg::OP_ADD, vcluster_pkg::elem_t'(take_bits(16)));
    finish_test();

    u_checker.report_summary(dut0.u_assert.fail_count);
    if (u_checker.errors == 0 && dut0.u_assert.fail_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
verilog/vcluster_pkg.sv
verilog/cmd_if.sv
verilog/cmd_broadcast.sv
verilog/vector_cluster.sv
verilog/result_gather.sv
verilog/vcluster_top.sv
dv/vcluster_assert.sv
dv/vcluster_checker.sv
dv/tb_vcluster.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_vcluster
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
